// File: decodePkg.sv
package decodePkg;

    typedef logic [31:0] wordT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;
    typedef logic [4:0]  regIdxT;
    typedef logic [2:0]  memFuncT;

    // primary opcodes.
    localparam opcodeT ALU    = 6'd0;
    localparam opcodeT BRANCH = 6'd1;
    localparam opcodeT J      = 6'd2;
    localparam opcodeT JAL    = 6'd3;
    localparam opcodeT BEQ    = 6'd4;
    localparam opcodeT BNE    = 6'd5;
    localparam opcodeT BLEZ   = 6'd6;
    localparam opcodeT BGTZ   = 6'd7;
    localparam opcodeT ADDI   = 6'd8;
    localparam opcodeT ADDIU  = 6'd9;
    localparam opcodeT SLTI   = 6'd10;
    localparam opcodeT SLTIU  = 6'd11;
    localparam opcodeT ANDI   = 6'd12;
    localparam opcodeT ORI    = 6'd13;
    localparam opcodeT XORI   = 6'd14;
    localparam opcodeT LUI    = 6'd15;
    localparam opcodeT MULL   = 6'd28;
    localparam opcodeT LB     = 6'd32;
    localparam opcodeT LH     = 6'd33;
    localparam opcodeT LWL    = 6'd34;
    localparam opcodeT LW     = 6'd35;
    localparam opcodeT LBU    = 6'd36;
    localparam opcodeT LHU    = 6'd37;
    localparam opcodeT LWR    = 6'd38;
    localparam opcodeT SB     = 6'd40;
    localparam opcodeT SH     = 6'd41;
    localparam opcodeT SWL    = 6'd42;
    localparam opcodeT SW     = 6'd43;
    localparam opcodeT SWR    = 6'd46;
    localparam opcodeT LL     = 6'd48;
    localparam opcodeT SC     = 6'd56;

    // function field, ALU group.
    localparam functT SLL   = 6'd0;
    localparam functT SRL   = 6'd2;
    localparam functT SRA   = 6'd3;
    localparam functT SLLV  = 6'd4;
    localparam functT SRLV  = 6'd6;
    localparam functT SRAV  = 6'd7;
    localparam functT JR    = 6'd8;
    localparam functT JALR  = 6'd9;
    localparam functT MOVZ  = 6'd10;
    localparam functT MOVN  = 6'd11;
    localparam functT MFHI  = 6'd16;
    localparam functT MTHI  = 6'd17;
    localparam functT MFLO  = 6'd18;
    localparam functT MTLO  = 6'd19;
    localparam functT MULT  = 6'd24;
    localparam functT MULTU = 6'd25;
    localparam functT ADD   = 6'd32;
    localparam functT ADDU  = 6'd33;
    localparam functT SUB   = 6'd34;
    localparam functT SUBU  = 6'd35;
    localparam functT AND   = 6'd36;
    localparam functT OR    = 6'd37;
    localparam functT XOR   = 6'd38;
    localparam functT NOR   = 6'd39;
    localparam functT SLT   = 6'd42;
    localparam functT SLTU  = 6'd43;

    // function field, MULL group.
    localparam functT MADD  = 6'd0;
    localparam functT MADDU = 6'd1;
    localparam functT MUL   = 6'd2;
    localparam functT MSUB  = 6'd4;
    localparam functT MSUBU = 6'd5;
    localparam functT CLZ   = 6'd32;
    localparam functT CLO   = 6'd33;

    // CLZ/CLO collide with ADD/ADDU, so the ALU sees free codes.
    localparam functT ALU_CLO = 6'd62;
    localparam functT ALU_CLZ = 6'd63;

    // REGIMM codes in the rt field.
    localparam regIdxT BLTZ   = 5'd0;
    localparam regIdxT BGEZ   = 5'd1;
    localparam regIdxT BLTZAL = 5'd16;
    localparam regIdxT BGEZAL = 5'd17;

    typedef enum logic [1:0] {
        dstNone = 2'd0,
        dstRd   = 2'd1,
        dstRa   = 2'd2
    } regDstE;

    typedef struct packed {
        wordT        pc;
        opcodeT      opcode;
        regIdxT      rs;
        regIdxT      rt;       // also the branch code.
        regIdxT      rd;
        functT       funct;
        logic [15:0] imm16;
        logic [25:0] target26;
    } instrFieldsT;

    typedef struct packed {
        logic    branch;
        logic    jump;
        logic    memRead;
        logic    memToReg;
        logic    aluOp;
        logic    mulOp;
        logic    memWrite;
        logic    aluSrc;
        logic    braSrc;
        logic    regWrite;
        logic    shiftSel;
        logic    immSize;
        logic    unsgnSel;
        regDstE  regDst;
        functT   func;
        memFuncT memFunc;
    } ctrlT;

    typedef struct packed {
        wordT   pc;
        ctrlT   ctrl;
        regIdxT rs;
        regIdxT rt;
        regIdxT destReg;
        wordT   immExt;
    } decodedT;

endpackage

// File: logic/fetchUnit.sv
module fetchUnit #(
    parameter decodePkg::wordT ResetPc = 32'h0
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   instrStrobe,
    input  decodePkg::wordT        instr,
    input  logic                   full,
    output logic                   push,
    output decodePkg::instrFieldsT fields
);

    decodePkg::wordT pc;

    // words arriving on a full queue are lost.
    assign push = instrStrobe && !full;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            pc <= ResetPc;
        else if (push)
            pc <= pc + 32'd4; // next word.
    end

    always_comb
    begin
        fields.pc       = pc;
        fields.opcode   = instr[31:26];
        fields.rs       = instr[25:21];
        fields.rt       = instr[20:16];
        fields.rd       = instr[15:11];
        fields.funct    = instr[5:0];
        fields.imm16    = instr[15:0];
        fields.target26 = instr[25:0];
    end

endmodule

// File: logic/instrQueue.sv
module instrQueue #(
    parameter int QueueDepth = 4
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   push,
    input  decodePkg::instrFieldsT pushData,
    input  logic                   pop,
    output decodePkg::instrFieldsT head,
    output logic                   full,
    output logic                   empty
);

    localparam int PtrW = $clog2(QueueDepth);

    decodePkg::instrFieldsT mem [QueueDepth];

    logic [PtrW-1:0] rdPtr;
    logic [PtrW-1:0] wrPtr;
    logic [PtrW:0]   count;
    logic            doPush;
    logic            doPop;

    assign doPush = push && !full;
    assign doPop  = pop && !empty;

    assign full  = (count == (PtrW+1)'(QueueDepth));
    assign empty = (count == '0);
    assign head  = mem[rdPtr]; // oldest entry.

    always_ff @(posedge clk)
    begin
        if (doPush)
            mem[wrPtr] <= pushData;
    end

    // pointers wrap on their own, depth is a power of two.
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doPush)
                wrPtr <= wrPtr + 1'b1;
            if (doPop)
                rdPtr <= rdPtr + 1'b1;
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither.
            endcase
        end
    end

endmodule

// File: logic/controlDecoder.sv
module controlDecoder (
    input  decodePkg::instrFieldsT fields,
    output decodePkg::ctrlT        ctrl
);

    always_comb
    begin
        ctrl        = '0;
        ctrl.regDst = decodePkg::dstNone;

        case (fields.opcode)
            decodePkg::ALU:
                case (fields.funct)
                    decodePkg::ADD,  decodePkg::ADDU, decodePkg::SUB,  decodePkg::SUBU,
                    decodePkg::SLL,  decodePkg::SLLV, decodePkg::SRA,  decodePkg::SRAV,
                    decodePkg::SRL,  decodePkg::SRLV, decodePkg::AND,  decodePkg::NOR,
                    decodePkg::OR,   decodePkg::XOR,  decodePkg::MOVN, decodePkg::MOVZ,
                    decodePkg::SLT,  decodePkg::SLTU, decodePkg::MFHI, decodePkg::MFLO:
                    begin
                        ctrl.regDst   = decodePkg::dstRd;
                        ctrl.func     = fields.funct;
                        ctrl.aluOp    = 1'b1;
                        ctrl.regWrite = 1'b1;
                    end

                    // results land in hi/lo only.
                    decodePkg::MULT, decodePkg::MULTU, decodePkg::MTHI, decodePkg::MTLO:
                    begin
                        ctrl.func  = fields.funct;
                        ctrl.aluOp = 1'b1;
                    end

                    decodePkg::JALR:
                    begin
                        ctrl.regDst   = decodePkg::dstRd;
                        ctrl.func     = decodePkg::JALR;
                        ctrl.jump     = 1'b1;
                        ctrl.regWrite = 1'b1;
                    end

                    decodePkg::JR:
                    begin
                        ctrl.func = decodePkg::JR;
                        ctrl.jump = 1'b1;
                    end

                    default: ;
                endcase

            decodePkg::BRANCH:
                case (fields.rt)
                    decodePkg::BLTZ, decodePkg::BGEZ:
                    begin
                        ctrl.unsgnSel = 1'b1;
                        ctrl.func     = {1'b0, fields.rt};
                        ctrl.branch   = 1'b1;
                        ctrl.braSrc   = 1'b1;
                    end

                    decodePkg::BLTZAL, decodePkg::BGEZAL:
                    begin
                        ctrl.unsgnSel = 1'b1;
                        ctrl.regDst   = decodePkg::dstRa; // link.
                        ctrl.func     = {1'b0, fields.rt};
                        ctrl.branch   = 1'b1;
                        ctrl.braSrc   = 1'b1;
                        ctrl.regWrite = 1'b1;
                    end

                    default: ;
                endcase

            decodePkg::MULL:
            begin
                ctrl.mulOp = 1'b1;
                case (fields.funct)
                    decodePkg::CLO:
                    begin
                        ctrl.regDst   = decodePkg::dstRd;
                        ctrl.func     = decodePkg::ALU_CLO;
                        ctrl.regWrite = 1'b1;
                    end

                    decodePkg::CLZ:
                    begin
                        ctrl.regDst   = decodePkg::dstRd;
                        ctrl.func     = decodePkg::ALU_CLZ;
                        ctrl.regWrite = 1'b1;
                    end

                    decodePkg::MADD, decodePkg::MADDU, decodePkg::MSUB, decodePkg::MSUBU:
                        ctrl.func = fields.funct; // accumulate into hi/lo.

                    decodePkg::MUL:
                    begin
                        ctrl.regDst   = decodePkg::dstRd;
                        ctrl.func     = decodePkg::MUL;
                        ctrl.regWrite = 1'b1;
                    end

                    default: ;
                endcase
            end

            decodePkg::ADDI, decodePkg::SLTI:
            begin
                ctrl.func     = (fields.opcode == decodePkg::ADDI) ? decodePkg::ADD
                                                                   : decodePkg::SLT;
                ctrl.aluOp    = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            decodePkg::ADDIU, decodePkg::SLTIU, decodePkg::ANDI,
            decodePkg::ORI,   decodePkg::XORI:
            begin
                ctrl.unsgnSel = 1'b1;
                ctrl.aluOp    = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (fields.opcode)
                    decodePkg::ADDIU: ctrl.func = decodePkg::ADDU;
                    decodePkg::SLTIU: ctrl.func = decodePkg::SLTU;
                    decodePkg::ANDI:  ctrl.func = decodePkg::AND;
                    decodePkg::ORI:   ctrl.func = decodePkg::OR;
                    default:          ctrl.func = decodePkg::XOR;
                endcase
            end

            decodePkg::LUI:
            begin
                ctrl.func     = decodePkg::ADD;
                ctrl.aluOp    = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.shiftSel = 1'b1; // immediate to upper half.
                ctrl.regWrite = 1'b1;
            end

            decodePkg::BEQ, decodePkg::BNE, decodePkg::BLEZ, decodePkg::BGTZ:
            begin
                ctrl.unsgnSel = 1'b1;
                ctrl.func     = fields.opcode;
                ctrl.branch   = 1'b1;
                ctrl.braSrc   = 1'b1;
            end

            decodePkg::J, decodePkg::JAL:
            begin
                ctrl.func    = fields.opcode;
                ctrl.jump    = 1'b1;
                ctrl.braSrc  = 1'b1;
                ctrl.immSize = 1'b1;
                if (fields.opcode == decodePkg::JAL)
                begin
                    ctrl.regDst   = decodePkg::dstRa;
                    ctrl.regWrite = 1'b1;
                end
            end

            decodePkg::LB,  decodePkg::LBU, decodePkg::LH, decodePkg::LHU,
            decodePkg::LW,  decodePkg::LWL, decodePkg::LWR:
            begin
                ctrl.func     = decodePkg::ADD; // address add.
                ctrl.memFunc  = fields.opcode[2:0];
                ctrl.aluOp    = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            decodePkg::SB,  decodePkg::SH,  decodePkg::SW,
            decodePkg::SWL, decodePkg::SWR:
            begin
                ctrl.func     = decodePkg::ADD;
                ctrl.memFunc  = fields.opcode[2:0];
                ctrl.aluOp    = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end

            // LL/SC not supported.
            decodePkg::LL, decodePkg::SC: ;
            default: ;
        endcase
    end

endmodule

// File: logic/decodeStage.sv
module decodeStage (
    input  logic                   clk,
    input  logic                   arstN,
    input  decodePkg::instrFieldsT head,
    input  logic                   empty,
    input  logic                   stall,
    output logic                   pop,
    output decodePkg::decodedT     decoded,
    output logic                   decodedStrobe
);

    decodePkg::ctrlT   ctrl;
    decodePkg::regIdxT destReg;
    decodePkg::wordT   immExt;

    controlDecoder i_controlDecoder (
        .fields (head),
        .ctrl   (ctrl)
    );

    assign pop = !empty && !stall;

    always_comb
    begin
        if (!ctrl.regWrite)
            destReg = '0;
        else
            case (ctrl.regDst)
                decodePkg::dstRd: destReg = head.rd;
                decodePkg::dstRa: destReg = 5'd31;
                default:          destReg = head.rt; // immediate and load forms.
            endcase
    end

    always_comb
    begin
        if (ctrl.immSize)
            immExt = {6'd0, head.target26};
        else if (ctrl.shiftSel)
            immExt = {head.imm16, 16'd0};
        else if (ctrl.unsgnSel)
            immExt = {16'd0, head.imm16};
        else
            immExt = {{16{head.imm16[15]}}, head.imm16};
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            decodedStrobe <= 1'b0;
        else
            decodedStrobe <= pop;
    end

    // bundle holds between pops.
    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            decoded.pc      <= head.pc;
            decoded.ctrl    <= ctrl;
            decoded.rs      <= head.rs;
            decoded.rt      <= head.rt;
            decoded.destReg <= destReg;
            decoded.immExt  <= immExt;
        end
    end

endmodule

// File: logic/decodeTop.sv
module decodeTop #(
    parameter int              QueueDepth = 4,
    parameter decodePkg::wordT ResetPc    = 32'h0
) (
    input  logic               clk,
    input  logic               arstN,
    input  logic               instrStrobe,
    input  decodePkg::wordT    instr,
    input  logic               stall,
    output logic               full,
    output decodePkg::decodedT decoded,
    output logic               decodedStrobe
);

    decodePkg::instrFieldsT pushData;
    decodePkg::instrFieldsT head;
    logic                   push;
    logic                   pop;
    logic                   empty;

    fetchUnit #(
        .ResetPc (ResetPc)
    ) i_fetchUnit (
        .clk         (clk),
        .arstN       (arstN),
        .instrStrobe (instrStrobe),
        .instr       (instr),
        .full        (full),
        .push        (push),
        .fields      (pushData)
    );

    instrQueue #(
        .QueueDepth (QueueDepth)
    ) i_instrQueue (
        .clk      (clk),
        .arstN    (arstN),
        .push     (push),
        .pushData (pushData),
        .pop      (pop),
        .head     (head),
        .full     (full),
        .empty    (empty)
    );

    decodeStage i_decodeStage (
        .clk           (clk),
        .arstN         (arstN),
        .head          (head),
        .empty         (empty),
        .stall         (stall),
        .pop           (pop),
        .decoded       (decoded),
        .decodedStrobe (decodedStrobe)
    );

endmodule

// File: bench/decodeTb.sv
module decodeTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int              QueueDepth = 4;
    localparam decodePkg::wordT ResetPc    = 32'h0040_0000;
    localparam int              Dropped    = 3;
    localparam int              NumWords   = 69 + QueueDepth + Dropped + 10;
    localparam int              CycleLimit = 40 * NumWords + 16;

    localparam decodePkg::functT AluFuncs [26] = '{
        decodePkg::ADD,  decodePkg::ADDU, decodePkg::SUB,   decodePkg::SUBU,
        decodePkg::AND,  decodePkg::OR,   decodePkg::XOR,   decodePkg::NOR,
        decodePkg::SLT,  decodePkg::SLTU, decodePkg::SLL,   decodePkg::SRL,
        decodePkg::SRA,  decodePkg::SLLV, decodePkg::SRLV,  decodePkg::SRAV,
        decodePkg::MOVN, decodePkg::MOVZ, decodePkg::MFHI,  decodePkg::MFLO,
        decodePkg::MULT, decodePkg::MULTU, decodePkg::MTHI, decodePkg::MTLO,
        decodePkg::JR,   decodePkg::JALR
    };
    // immediate, branch, jump and memory forms, then unsupported opcodes.
    localparam decodePkg::opcodeT OpcodeList [29] = '{
        decodePkg::ADDI, decodePkg::ADDIU, decodePkg::SLTI, decodePkg::SLTIU,
        decodePkg::ANDI, decodePkg::ORI,   decodePkg::XORI, decodePkg::LUI,
        decodePkg::BEQ,  decodePkg::BNE,   decodePkg::BLEZ, decodePkg::BGTZ,
        decodePkg::J,    decodePkg::JAL,   decodePkg::LB,   decodePkg::LH,
        decodePkg::LWL,  decodePkg::LW,    decodePkg::LBU,  decodePkg::LHU,
        decodePkg::LWR,  decodePkg::SB,    decodePkg::SH,   decodePkg::SWL,
        decodePkg::SW,   decodePkg::SWR,   decodePkg::LL,   decodePkg::SC, 6'd63
    };
    localparam decodePkg::regIdxT RegimmCodes [5] = '{
        decodePkg::BLTZ, decodePkg::BGEZ, decodePkg::BLTZAL, decodePkg::BGEZAL, 5'd2
    };
    localparam decodePkg::functT MullFuncs [8] = '{
        decodePkg::MADD, decodePkg::MADDU, decodePkg::MUL, decodePkg::MSUB,
        decodePkg::MSUBU, decodePkg::CLZ, decodePkg::CLO, 6'd3
    };

    logic               clk;
    logic               arstN;
    logic               instrStrobe;
    decodePkg::wordT    instr;
    logic               stall;
    logic               full;
    decodePkg::decodedT decoded;
    logic               decodedStrobe;

    integer             seed = 32'hbf9a74ed;
    decodePkg::decodedT expQ [$];
    decodePkg::decodedT expHead = '0;
    int                 expCount = 0;
    int                 qOcc = 0;
    int                 accepted = 0;
    int                 emitted = 0;
    int                 cycles = 0;
    logic               expStrobe = 1'b0;
    logic               modelPush;
    logic               modelPop;
    logic               flowCheck;
    logic               freshStrobe;

    decodeTop #(
        .QueueDepth (QueueDepth),
        .ResetPc    (ResetPc)
    ) i_decodeTop (
        .clk           (clk),
        .arstN         (arstN),
        .instrStrobe   (instrStrobe),
        .instr         (instr),
        .stall         (stall),
        .full          (full),
        .decoded       (decoded),
        .decodedStrobe (decodedStrobe)
    );

    always #2 clk = !clk;

    function automatic decodePkg::ctrlT expectCtrl(decodePkg::wordT w);
        decodePkg::ctrlT   c;
        decodePkg::opcodeT op;
        decodePkg::functT  fn;
        decodePkg::regIdxT code;
        logic              isLoad;
        logic              known;
        c      = '0;
        op     = w[31:26];
        fn     = w[5:0];
        code   = w[20:16];
        isLoad = op[3] == 1'b0;
        known  = 1'b0;
        if (op == decodePkg::ALU)
        begin
            foreach (AluFuncs[i])
                if (AluFuncs[i] == fn)
                    known = 1'b1;
            c.func     = fn;
            c.aluOp    = !(fn inside {decodePkg::JR, decodePkg::JALR});
            c.jump     = fn inside {decodePkg::JR, decodePkg::JALR};
            c.regWrite = !(fn inside {decodePkg::MULT, decodePkg::MULTU, decodePkg::MTHI,
                                      decodePkg::MTLO, decodePkg::JR});
            if (!known)
                c = '0; // unused function code.
        end
        else if (op == decodePkg::BRANCH &&
                 code inside {decodePkg::BLTZ, decodePkg::BGEZ,
                              decodePkg::BLTZAL, decodePkg::BGEZAL})
        begin
            c.branch   = 1'b1;
            c.braSrc   = 1'b1;
            c.unsgnSel = 1'b1;
            c.func     = {1'b0, code};
            c.regWrite = code inside {decodePkg::BLTZAL, decodePkg::BGEZAL};
        end
        else if (op == decodePkg::MULL)
        begin
            c.mulOp    = 1'b1;
            c.regWrite = fn inside {decodePkg::MUL, decodePkg::CLO, decodePkg::CLZ};
            if (fn inside {decodePkg::MADD, decodePkg::MADDU, decodePkg::MUL,
                           decodePkg::MSUB, decodePkg::MSUBU})
                c.func = fn;
            else if (fn == decodePkg::CLO)
                c.func = decodePkg::ALU_CLO;
            else if (fn == decodePkg::CLZ)
                c.func = decodePkg::ALU_CLZ;
        end
        else if (op inside {[decodePkg::ADDI:decodePkg::LUI]})
        begin
            c.aluOp    = 1'b1;
            c.aluSrc   = 1'b1;
            c.regWrite = 1'b1;
            c.shiftSel = op == decodePkg::LUI;
            c.unsgnSel = op inside {decodePkg::ADDIU, decodePkg::SLTIU, decodePkg::ANDI,
                                    decodePkg::ORI, decodePkg::XORI};
            case (op)
                decodePkg::ADDIU: c.func = decodePkg::ADDU;
                decodePkg::SLTI:  c.func = decodePkg::SLT;
                decodePkg::SLTIU: c.func = decodePkg::SLTU;
                decodePkg::ANDI:  c.func = decodePkg::AND;
                decodePkg::ORI:   c.func = decodePkg::OR;
                decodePkg::XORI:  c.func = decodePkg::XOR;
                default:          c.func = decodePkg::ADD; // ADDI and LUI.
            endcase
        end
        else if (op inside {[decodePkg::J:decodePkg::BGTZ]})
        begin
            c.func     = op;
            c.braSrc   = 1'b1;
            c.branch   = op inside {[decodePkg::BEQ:decodePkg::BGTZ]};
            c.unsgnSel = c.branch;
            c.jump     = !c.branch;
            c.immSize  = !c.branch;
            c.regWrite = op == decodePkg::JAL;
        end
        else if (op inside {[decodePkg::LB:decodePkg::LWR], decodePkg::SB, decodePkg::SH,
                            decodePkg::SWL, decodePkg::SW, decodePkg::SWR})
        begin
            c.func     = decodePkg::ADD;
            c.memFunc  = op[2:0];
            c.aluOp    = 1'b1;
            c.aluSrc   = 1'b1;
            c.memRead  = isLoad;
            c.memToReg = isLoad;
            c.regWrite = isLoad;
            c.memWrite = !isLoad;
        end
        // link writes go to register 31 and R-type writes to rd.
        if (c.regWrite && (op == decodePkg::JAL || op == decodePkg::BRANCH))
            c.regDst = decodePkg::dstRa;
        else if (c.regWrite && (op == decodePkg::ALU || op == decodePkg::MULL))
            c.regDst = decodePkg::dstRd;
        return c;
    endfunction

    function automatic decodePkg::decodedT expectDecoded(decodePkg::wordT w,
                                                         decodePkg::wordT pc);
        decodePkg::decodedT d;
        d.pc   = pc;
        d.ctrl = expectCtrl(w);
        d.rs   = w[25:21];
        d.rt   = w[20:16];
        if (!d.ctrl.regWrite)
            d.destReg = '0;
        else if (d.ctrl.regDst == decodePkg::dstRd)
            d.destReg = w[15:11];
        else if (d.ctrl.regDst == decodePkg::dstRa)
            d.destReg = 5'd31;
        else
            d.destReg = w[20:16];
        if (d.ctrl.immSize)
            d.immExt = {6'd0, w[25:0]};
        else if (d.ctrl.shiftSel)
            d.immExt = {w[15:0], 16'd0};
        else if (d.ctrl.unsgnSel)
            d.immExt = {16'd0, w[15:0]};
        else
            d.immExt = {{16{w[15]}}, w[15:0]};
        return d;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic sendWord(input decodePkg::wordT w);
        instr       = w;
        instrStrobe = 1'b1;
        @(negedge clk);
        instrStrobe = 1'b0;
        repeat ($unsigned($random(seed)) % 2) @(negedge clk);
    endtask

    task automatic sendR(input decodePkg::opcodeT op, input decodePkg::functT fn);
        decodePkg::wordT w;
        w        = $random(seed);
        w[31:26] = op;
        w[5:0]   = fn;
        sendWord(w);
    endtask

    task automatic sendI(input decodePkg::opcodeT op);
        decodePkg::wordT w;
        w        = $random(seed);
        w[31:26] = op;
        sendWord(w);
    endtask

    task automatic sendRegimm(input decodePkg::regIdxT code);
        decodePkg::wordT w;
        w         = $random(seed);
        w[31:26]  = decodePkg::BRANCH;
        w[20:16]  = code;
        sendWord(w);
    endtask

    task automatic drain();
        while (expCount != 0)
            @(negedge clk);
    endtask

    // reference model of queue occupancy and decode register.
    always @(posedge clk)
    begin
        if (arstN)
        begin
            if (expStrobe)
                void'(expQ.pop_front());
            if (decodedStrobe)
                emitted++;
            modelPop  = !stall && qOcc > 0;
            modelPush = instrStrobe && qOcc < QueueDepth;
            if (modelPush)
            begin
                expQ.push_back(expectDecoded(instr, ResetPc + 32'(4 * accepted)));
                accepted++;
            end
            qOcc      = qOcc + int'(modelPush) - int'(modelPop);
            expStrobe = modelPop;
            expCount  = expQ.size();
            expHead   = (expCount > 0) ? expQ[0] : '0;
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > CycleLimit)
            failRun($sformatf("run hung: not finished after %0d cycles", CycleLimit));
    end

    assign freshStrobe = instrStrobe && !stall && expCount == 0;

    strobeMatch: assert property (@(posedge clk) disable iff (!arstN)
        decodedStrobe == expStrobe)
        else failRun($sformatf("ERROR at %0t ns: decodedStrobe is %b, expected %b",
                               $time, $sampled(decodedStrobe), $sampled(expStrobe)));
    pcMatch: assert property (@(posedge clk) disable iff (!arstN)
        decodedStrobe |-> decoded.pc == expHead.pc)
        else failRun($sformatf("ERROR at %0t ns: pc is %h, expected %h",
                               $time, $sampled(decoded.pc), $sampled(expHead.pc)));
    ctrlMatch: assert property (@(posedge clk) disable iff (!arstN)
        decodedStrobe |-> decoded.ctrl == expHead.ctrl)
        else failRun($sformatf("ERROR at %0t ns: ctrl is %h, expected %h",
                               $time, $sampled(decoded.ctrl), $sampled(expHead.ctrl)));
    regMatch: assert property (@(posedge clk) disable iff (!arstN)
        decodedStrobe |-> {decoded.rs, decoded.rt, decoded.destReg}
                          == {expHead.rs, expHead.rt, expHead.destReg})
        else failRun($sformatf("ERROR at %0t ns: rs/rt/destReg is %h, expected %h", $time,
                               $sampled({decoded.rs, decoded.rt, decoded.destReg}),
                               $sampled({expHead.rs, expHead.rt, expHead.destReg})));
    immMatch: assert property (@(posedge clk) disable iff (!arstN)
        decodedStrobe |-> decoded.immExt == expHead.immExt)
        else failRun($sformatf("ERROR at %0t ns: immExt is %h, expected %h",
                               $time, $sampled(decoded.immExt), $sampled(expHead.immExt)));
    fullMatch: assert property (@(posedge clk) disable iff (!arstN)
        full == (qOcc == QueueDepth))
        else failRun($sformatf("ERROR at %0t ns: full is %b with %0d words queued",
                               $time, $sampled(full), $sampled(qOcc)));
    stallQuiet: assert property (@(posedge clk) disable iff (!arstN)
        decodedStrobe |-> $past(!stall))
        else failRun("output strobe seen although stall was high");
    flowLatency: assert property (@(posedge clk) disable iff (!arstN)
        flowCheck && $past(freshStrobe, 2) |-> decodedStrobe)
        else failRun("unstalled word did not come out two cycles after its strobe");

    initial
    begin
        clk         = 1'b0;
        arstN       = 1'b0;
        instrStrobe = 1'b0;
        instr       = '0;
        stall       = 1'b0;
        flowCheck   = 1'b0;
        repeat (16) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);

        foreach (AluFuncs[i])
            sendR(decodePkg::ALU, AluFuncs[i]);
        sendR(decodePkg::ALU, 6'd1); // undefined function code.
        foreach (OpcodeList[i])
            sendI(OpcodeList[i]);
        foreach (RegimmCodes[i])
            sendRegimm(RegimmCodes[i]);
        foreach (MullFuncs[i])
            sendR(decodePkg::MULL, MullFuncs[i]);
        drain();

        // fill the queue under stall so the last strobes are lost.
        stall = 1'b1;
        repeat (QueueDepth + Dropped) sendWord($random(seed));
        repeat (8 + $unsigned($random(seed)) % 24) @(negedge clk);
        stall = 1'b0;
        drain();

        flowCheck = 1'b1;
        repeat (10)
        begin
            @(negedge clk);
            sendWord($random(seed));
            drain();
        end
        flowCheck = 1'b0;
        @(negedge clk);

        if (emitted == accepted && accepted == NumWords - Dropped)
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
            failRun($sformatf("ERROR at %0t ns: %0d words accepted, %0d emitted, %0d expected",
                              $time, accepted, emitted, NumWords - Dropped));
    end

endmodule

// File: decodeTop.f
decodePkg.sv
logic/fetchUnit.sv
logic/instrQueue.sv
logic/controlDecoder.sv
logic/decodeStage.sv
logic/decodeTop.sv
bench/decodeTb.sv

// File: Makefile
SIM = obj_dir/VdecodeTb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): decodeTop.f decodePkg.sv logic/*.sv bench/decodeTb.sv
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module decodeTb -f decodeTop.f -o VdecodeTb

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
